/* design/aes_config.svh */
// AES-128 core configuration
// round count and the block and word widths shared by the packages and RTL

`ifndef AES_CONFIG_SVH
`define AES_CONFIG_SVH

// AES-128 runs ten rounds after the initial key addition
`define AES_ROUNDS 10

`define AES_BLOCK_BITS 128

`define AES_WORD_BITS 32

`endif

/* design/aesTypesPkg.sv */
// AES data types
// block, word, byte and round-index types used across the encryption core

`include "aes_config.svh"

package aesTypesPkg;

	// one 128-bit state or key block, byte 0 of FIPS-197 in the top bits
	typedef logic [`AES_BLOCK_BITS-1:0] aesBlockT;

	// one column of the state or one key schedule word
	typedef logic [`AES_WORD_BITS-1:0] aesWordT;

	typedef logic [7:0] aesByteT;

	// wide enough for rounds 0 to 15
	typedef logic [3:0] roundIdxT;

endpackage

/* design/aesMathPkg.sv */
// GF(2^8) arithmetic for AES
// field multiply and inverse, with the S-box computed from the inverse

package aesMathPkg;

	// multiply by x, reducing by the AES polynomial
	function automatic aesTypesPkg::aesByteT xtime(input aesTypesPkg::aesByteT a);
		return {a[6:0], 1'b0} ^ (8'h1b & {8{a[7]}});
	endfunction

	function automatic aesTypesPkg::aesByteT gfMul(input aesTypesPkg::aesByteT a,
			input aesTypesPkg::aesByteT b);
		aesTypesPkg::aesByteT acc;
		aesTypesPkg::aesByteT term;
		acc = 8'h00;
		term = a;
		for (int i = 0; i < 8; i++) begin
			if (b[i]) begin
				acc = acc ^ term;
			end
			term = xtime(term);
		end
		return acc;
	endfunction

	// a^254 is the inverse of a, and zero comes out as zero on its own
	function automatic aesTypesPkg::aesByteT gfInverse(input aesTypesPkg::aesByteT a);
		aesTypesPkg::aesByteT acc;
		aesTypesPkg::aesByteT sq;
		acc = 8'h01;
		sq = a;
		for (int i = 1; i < 8; i++) begin
			sq = gfMul(sq, sq);
			acc = gfMul(acc, sq);
		end
		return acc;
	endfunction

	function automatic aesTypesPkg::aesByteT sbox(input aesTypesPkg::aesByteT a);
		aesTypesPkg::aesByteT x;
		x = gfInverse(a);
		// affine map written as xor of the byte with its left rotations
		return x ^ {x[6:0], x[7]} ^ {x[5:0], x[7:6]} ^ {x[4:0], x[7:5]} ^
			{x[3:0], x[7:4]} ^ 8'h63;
	endfunction

	function automatic aesTypesPkg::aesWordT subWord(input aesTypesPkg::aesWordT w);
		return {sbox(w[31:24]), sbox(w[23:16]), sbox(w[15:8]), sbox(w[7:0])};
	endfunction

endpackage

/* design/roundCounter.sv */
// AES round counter
// tracks the round being executed and flags the final one

`timescale 1ns/10ps

`include "aes_config.svh"

module roundCounter (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  load,
	input  logic                  step,
	output aesTypesPkg::roundIdxT round,
	output logic                  lastRound
);

	// round 1 is the first one after the initial key addition
	always_ff @(posedge clk) begin
		if (rst) begin
			round <= '0;
		end else if (load) begin
			round <= aesTypesPkg::roundIdxT'(1);
		end else if (step) begin
			round <= round + aesTypesPkg::roundIdxT'(1);
		end
	end

	// the final round drops MixColumns and ends the block
	assign lastRound = (round == aesTypesPkg::roundIdxT'(`AES_ROUNDS));

endmodule

/* design/roundControl.sv */
// AES round sequencer
// accepts a start strobe, steps the rounds and emits a one-cycle done

`timescale 1ns/10ps

module roundControl (
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  logic lastRound,
	output logic load,
	output logic step,
	output logic busy,
	output logic done
);

	typedef enum logic {
		IDLE,
		RUN
	} ctrlStateT;

	ctrlStateT ctrlState;
	ctrlStateT nextState;

	// the done cycle still counts as busy, so a start there is dropped
	assign busy = (ctrlState == RUN) || done;
	assign load = start && !busy;
	assign step = (ctrlState == RUN);

	always_comb begin
		nextState = ctrlState;
		case (ctrlState)
			IDLE: begin
				if (load) begin
					nextState = RUN;
				end
			end
			RUN: begin
				if (lastRound) begin
					nextState = IDLE;
				end
			end
			default: nextState = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ctrlState <= IDLE;
			done <= 1'b0;
		end else begin
			ctrlState <= nextState;
			done <= step && lastRound;
		end
	end

endmodule

/* design/keyExpander.sv */
// AES-128 key schedule
// derives the round keys on the fly, one per executed round

`timescale 1ns/10ps

module keyExpander (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  load,
	input  logic                  step,
	input  aesTypesPkg::aesBlockT key,
	output aesTypesPkg::aesBlockT roundKey
);

	// holds the key of the previous round while roundKey is the one in use now
	aesTypesPkg::aesBlockT prevKey;
	aesTypesPkg::aesByteT rcon;

	aesTypesPkg::aesWordT w0;
	aesTypesPkg::aesWordT w1;
	aesTypesPkg::aesWordT w2;
	aesTypesPkg::aesWordT w3;
	aesTypesPkg::aesWordT temp;

	always_comb begin
		temp = aesMathPkg::subWord({prevKey[23:0], prevKey[31:24]}) ^ {rcon, 24'h000000};
		w0 = prevKey[127:96] ^ temp;
		w1 = prevKey[95:64] ^ w0;
		w2 = prevKey[63:32] ^ w1;
		w3 = prevKey[31:0] ^ w2;
	end

	assign roundKey = {w0, w1, w2, w3};

	always_ff @(posedge clk) begin
		if (rst) begin
			rcon <= 8'h00;
		end else if (load) begin
			rcon <= 8'h01;
		end else if (step) begin
			rcon <= aesMathPkg::xtime(rcon);
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			prevKey <= key;
		end else if (step) begin
			prevKey <= roundKey;
		end
	end

endmodule

/* design/roundDatapath.sv */
// AES round datapath
// holds the cipher state and applies one full round on each step

`timescale 1ns/10ps

module roundDatapath (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  load,
	input  logic                  step,
	input  aesTypesPkg::aesBlockT plainText,
	input  aesTypesPkg::aesBlockT key,
	input  aesTypesPkg::aesBlockT roundKey,
	input  logic                  lastRound,
	output aesTypesPkg::aesBlockT state
);

	aesTypesPkg::aesBlockT subbed;
	aesTypesPkg::aesBlockT shifted;
	aesTypesPkg::aesBlockT mixed;

	function automatic aesTypesPkg::aesWordT mixColumn(input aesTypesPkg::aesWordT col);
		aesTypesPkg::aesByteT a0;
		aesTypesPkg::aesByteT a1;
		aesTypesPkg::aesByteT a2;
		aesTypesPkg::aesByteT a3;
		a0 = col[31:24];
		a1 = col[23:16];
		a2 = col[15:8];
		a3 = col[7:0];
		// times 3 is xtime of the byte xored with the byte itself
		return {aesMathPkg::xtime(a0 ^ a1) ^ a1 ^ a2 ^ a3,
			a0 ^ aesMathPkg::xtime(a1 ^ a2) ^ a2 ^ a3,
			a0 ^ a1 ^ aesMathPkg::xtime(a2 ^ a3) ^ a3,
			aesMathPkg::xtime(a3 ^ a0) ^ a0 ^ a1 ^ a2};
	endfunction

	// state byte n sits at row n%4, column n/4, byte 0 in the top bits
	always_comb begin
		for (int i = 0; i < 16; i++) begin
			subbed[127-8*i -: 8] = aesMathPkg::sbox(state[127-8*i -: 8]);
		end
		for (int c = 0; c < 4; c++) begin
			for (int r = 0; r < 4; r++) begin
				shifted[127-8*(r+4*c) -: 8] = subbed[127-8*(r+4*((c+r)%4)) -: 8];
			end
		end
		for (int c = 0; c < 4; c++) begin
			mixed[127-32*c -: 32] = mixColumn(shifted[127-32*c -: 32]);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= '0;
		end else if (load) begin
			state <= plainText ^ key;
		end else if (step) begin
			state <= (lastRound ? shifted : mixed) ^ roundKey;
		end
	end

endmodule

/* design/aesEncryptTop.sv */
// AES-128 iterative encryption core
// one round per clock with the key schedule expanded alongside

`timescale 1ns/10ps

module aesEncryptTop (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  start,
	input  aesTypesPkg::aesBlockT plainText,
	input  aesTypesPkg::aesBlockT key,
	output aesTypesPkg::aesBlockT cipherText,
	output logic                  done,
	output logic                  busy
);

	logic load;
	logic step;
	logic lastRound;
	aesTypesPkg::aesBlockT roundKey;

	roundControl u_roundControl (
		.clk      (clk),
		.rst      (rst),
		.start    (start),
		.lastRound(lastRound),
		.load     (load),
		.step     (step),
		.busy     (busy),
		.done     (done)
	);

	// only the last-round flag is needed outside the counter
	roundCounter u_roundCounter (
		.clk      (clk),
		.rst      (rst),
		.load     (load),
		.step     (step),
		.round    (),
		.lastRound(lastRound)
	);

	keyExpander u_keyExpander (
		.clk     (clk),
		.rst     (rst),
		.load    (load),
		.step    (step),
		.key     (key),
		.roundKey(roundKey)
	);

	// the state register holds the result until the next accepted start
	roundDatapath u_roundDatapath (
		.clk      (clk),
		.rst      (rst),
		.load     (load),
		.step     (step),
		.plainText(plainText),
		.key      (key),
		.roundKey (roundKey),
		.lastRound(lastRound),
		.state    (cipherText)
	);

endmodule

/* tests/aesEncrypt_sva.sv */
// AES-128 core strobe assertions
// checks the done strobe width, its latency and the busy release

`timescale 1ns/10ps

module aesEncryptSva (
	input logic clk,
	input logic rst,
	input logic start,
	input logic busy,
	input logic done
);

	doneSingleCycle: assert property (@(posedge clk) disable iff (rst) done |=> !done)
		else $error("done stayed high for two cycles");

	// an accepted start is one seen while the core is idle
	doneLatency: assert property (@(posedge clk) disable iff (rst)
		$past(start && !busy, 11) |-> done)
		else $error("done did not follow an accepted start after 11 cycles");

	busyReleased: assert property (@(posedge clk) disable iff (rst) done |=> !busy)
		else $error("busy still high in the cycle after done");

endmodule

bind aesEncryptTop aesEncryptSva u_sva (
	.clk  (clk),
	.rst  (rst),
	.start(start),
	.busy (busy),
	.done (done)
);

/* tests/aesEncryptTb.sv */
// AES-128 encryption core testbench
// applies published vectors from a table and checks result, latency and strobes

`timescale 1ns/10ps

module aesEncryptTb;

	localparam int rowCount = 3;
	localparam int doneLatency = 11;
	localparam int doneTimeout = 40;

	logic clk;
	logic rst;
	logic start;
	aesTypesPkg::aesBlockT plainText;
	aesTypesPkg::aesBlockT key;
	aesTypesPkg::aesBlockT cipherText;
	logic done;
	logic busy;

	aesTypesPkg::aesBlockT keyTab [rowCount];
	aesTypesPkg::aesBlockT plainTab [rowCount];
	aesTypesPkg::aesBlockT cipherTab [rowCount];

	logic [31:0] rngState;
	int testCount;
	int failCount;
	int errorCount;
	int gap;
	bit timedOut;

	aesEncryptTop u_dut (
		.clk       (clk),
		.rst       (rst),
		.start     (start),
		.plainText (plainText),
		.key       (key),
		.cipherText(cipherText),
		.done      (done),
		.busy      (busy)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#10 clk = ~clk;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	task automatic reportTest(input string name, input int errs);
		testCount++;
		errorCount += errs;
		if (errs == 0) begin
			$display("test %s: ok", name);
		end else begin
			failCount++;
			$display("test %s: %0d errors", name, errs);
		end
	endtask

	task automatic checkResetState();
		int errs;
		errs = 0;
		if (done !== 1'b0 || busy !== 1'b0) begin
			$display("** Error: done = %h, busy = %h, expected %h after reset", done, busy, 1'b0);
			errs++;
		end
		if (cipherText !== 128'h0) begin
			$display("** Error: cipherText = %h, expected %h after reset", cipherText, 128'h0);
			errs++;
		end
		reportTest("reset", errs);
	endtask

	// starts at a falling edge and returns at the falling edge of the last check of the block
	task automatic encryptAndCheck(input int row, input int intrudeRow, input string name);
		int cycles;
		int errs;
		int watch;
		errs = 0;
		start = 1'b1;
		plainText = plainTab[row];
		key = keyTab[row];
		@(negedge clk);
		start = 1'b0;
		plainText = ~plainTab[row];
		key = ~keyTab[row];
		cycles = 1;
		if (busy !== 1'b1) begin
			$display("** Error: busy = %h, expected %h after start in %s", busy, 1'b1, name);
			errs++;
		end
		while (done !== 1'b1 && cycles < doneTimeout) begin
			// a second block offered mid-run must be dropped
			start = (intrudeRow >= 0 && cycles == 2);
			if (start) begin
				plainText = plainTab[intrudeRow];
				key = keyTab[intrudeRow];
			end
			@(negedge clk);
			cycles++;
		end
		start = 1'b0;
		if (done !== 1'b1) begin
			$display("%s: done did not rise within %0d cycles, stopping the run", name, cycles);
			timedOut = 1'b1;
			errs++;
		end else begin
			if (cycles != doneLatency) begin
				$display("** Error: done latency = %h, expected %h in %s", cycles, doneLatency,
					name);
				errs++;
			end
			if (cipherText !== cipherTab[row]) begin
				$display("** Error: cipherText = %h, expected %h in %s", cipherText,
					cipherTab[row], name);
				errs++;
			end
			watch = (intrudeRow >= 0) ? doneLatency + 2 : 1;
			for (int i = 0; i < watch; i++) begin
				@(negedge clk);
				if (done !== 1'b0 || (i == 0 && busy !== 1'b0)) begin
					$display("** Error: done = %h, busy = %h, expected %h in %s at done+%0d",
						done, busy, 1'b0, name, i + 1);
					errs++;
				end
			end
		end
		reportTest(name, errs);
	endtask

	initial begin
		rst = 1'b1;
		start = 1'b0;
		plainText = '0;
		key = '0;
		rngState = 32'h74c1_2ad7;
		testCount = 0;
		failCount = 0;
		errorCount = 0;
		timedOut = 1'b0;
		// FIPS-197 appendix C.1, appendix B, then all-zero key and block
		keyTab[0] = 128'h000102030405060708090a0b0c0d0e0f;
		plainTab[0] = 128'h00112233445566778899aabbccddeeff;
		cipherTab[0] = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
		keyTab[1] = 128'h2b7e151628aed2a6abf7158809cf4f3c;
		plainTab[1] = 128'h3243f6a8885a308d313198a2e0370734;
		cipherTab[1] = 128'h3925841d02dc09fbdc118597196a0b32;
		keyTab[2] = 128'h0;
		plainTab[2] = 128'h0;
		cipherTab[2] = 128'h66e94bd4ef8a2c3b884cfa59ca342b2e;
		repeat (5) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		checkResetState();
		for (int row = 0; row < rowCount; row++) begin
			rngState = xorshift(rngState);
			gap = int'(rngState % 32'd4);
			repeat (gap) @(negedge clk);
			if (!timedOut) begin
				encryptAndCheck(row, -1, $sformatf("row%0d", row));
			end
		end
		if (!timedOut) begin
			encryptAndCheck(0, 1, "busyStart");
		end
		// each start lands in the cycle right after the previous done
		for (int row = 0; row < rowCount; row++) begin
			if (!timedOut) begin
				encryptAndCheck(row, -1, $sformatf("backToBack%0d", row));
			end
		end
		$display("%0d tests, %0d failed, %0d errors", testCount, failCount, errorCount);
		if (failCount == 0 && !timedOut) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

/* filelist.f */
+incdir+design
design/aesTypesPkg.sv
design/aesMathPkg.sv
design/roundCounter.sv
design/roundControl.sv
design/keyExpander.sv
design/roundDatapath.sv
design/aesEncryptTop.sv
tests/aesEncrypt_sva.sv
tests/aesEncryptTb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f filelist.f --top-module aesEncryptTb -o simv
	out="$$(./obj_dir/simv)"; echo "$$out"; echo "$$out" | grep -qF "Simulation finished: PASS"

clean:
	rm -rf obj_dir
